// File: stack_cpu_top.f
+incdir+bench
common/stack_cpu_pkg.sv
source/program_mem.sv
core/insn_decoder.sv
core/stack_alu.sv
core/stack_cpu_core.sv
source/data_mem.sv
source/stack_cpu_top.sv
bench/tb_stack_cpu.sv

// File: run_sim.sh
#!/bin/sh
# builds the stack cpu testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  -f stack_cpu_top.f --top-module tb_stack_cpu -o sim_tb_stack_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb_stack_cpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

// File: bench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// instruction word from opcode and low byte
function automatic logic [15:0] enc(input logic [7:0] op, input logic [7:0] low);
  return {op, low};
endfunction

// galois lfsr, 16 bit, taps b400h
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// one lfsr step per bit taken
task automatic take_bits(input int n, output logic [15:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[14:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
endtask

// append one word to the program image
task automatic emit(input logic [15:0] w);
  prog.push_back(w);
  exec_steps++;
endtask

task automatic expect_out(input logic [15:0] v);
  exp_q.push_back(v);
endtask

// expected alu result, s0 is the stack top
function automatic logic [15:0] ref_alu(input stack_cpu_pkg::alu_fn_e fn,
                                        input logic [15:0] s0,
                                        input logic [15:0] s1);
  logic [31:0] prod;
  prod = s0 * s1;
  case (fn)
    stack_cpu_pkg::alu_pass0: return s0;
    stack_cpu_pkg::alu_pass1: return s1;
    stack_cpu_pkg::alu_add: return s0 + s1;
    stack_cpu_pkg::alu_sub: return s0 - s1;
    stack_cpu_pkg::alu_mul: return prod[15:0];
    // second entry lands in the high byte
    stack_cpu_pkg::alu_join: return s0 | {s1[7:0], 8'h00};
    stack_cpu_pkg::alu_and: return s0 & s1;
    stack_cpu_pkg::alu_lt: return (s0 < s1) ? 16'd1 : 16'd0;
    stack_cpu_pkg::alu_eq: return (s0 == s1) ? 16'd1 : 16'd0;
    stack_cpu_pkg::alu_neq: return (s0 != s1) ? 16'd1 : 16'd0;
    default: return 16'd0;
  endcase
endfunction

`endif

// File: bench/tb_stack_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_stack_cpu;

  logic clk;
  logic rst;
  logic prog_we;
  logic [9:0] prog_addr;
  logic [15:0] prog_data;
  logic io_req;
  logic [15:0] io_data;
  logic io_ack;
  logic halted;

  // program image and expected outputs of the current test
  logic [15:0] prog[$];
  logic [15:0] exp_q[$];
  logic [15:0] got_q[$];
  int exec_steps;
  logic [15:0] lfsr_state = 16'd83;

  string cur_name;
  int err_cnt;
  int check_cnt;
  int test_cnt;
  int cycle_cnt;
  int run_limit;

  // responder scratch
  logic [15:0] ack_delay;
  logic [15:0] held_data;
  // compare scratch
  logic [15:0] got_v;
  logic [15:0] exp_v;

  `include "tb_programs.svh"

  stack_cpu_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .io_req    (io_req),
    .io_data   (io_data),
    .io_ack    (io_ack),
    .halted    (halted)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // run time guard, cleared while in reset
  always @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > run_limit) begin
        $display("timeout: program %s never halted", cur_name);
        $display("Test failed");
        $finish;
      end
    end
  end

  // output port responder, random ack delay of 0 to 15 cycles
  initial begin
    io_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && io_req && !io_ack) begin
        take_bits(4, ack_delay);
        held_data = io_data;
        repeat (ack_delay) begin
          @(negedge clk);
          assert (io_req && io_data == held_data) else begin
            $display("%s: io_data changed or io_req dropped before ack", cur_name);
            err_cnt++;
          end
        end
        got_q.push_back(io_data);
        io_ack = 1'b1;
        // hold ack until req goes away
        do begin
          @(negedge clk);
        end while (io_req);
        io_ack = 1'b0;
      end
    end
  end

  // compares received words in order
  always @(posedge clk) begin
    if (got_q.size() > 0) begin
      got_v = got_q.pop_front();
      check_cnt++;
      if (exp_q.size() == 0) begin
        assert (0) else begin
          $display("%s: unexpected extra output %h", cur_name, got_v);
          err_cnt++;
        end
      end else begin
        exp_v = exp_q.pop_front();
        assert (got_v == exp_v) else begin
          $display("FAIL %s expected %h actual %h", cur_name, exp_v, got_v);
          err_cnt++;
        end
      end
    end
  end

  task automatic start_test(input string name);
    cur_name = name;
    prog.delete();
    exp_q.delete();
    got_q.delete();
    exec_steps = 0;
  endtask

  // load while in reset, release, wait for halt, then watch
  task automatic run_program();
    int err_before;
    err_before = err_cnt;
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      prog_we = 1'b1;
      prog_addr = 10'(i);
      prog_data = prog[i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (8) @(negedge clk);
    run_limit = 3 * exec_steps + 20 * exp_q.size() + 50 + 100;
    rst = 1'b0;
    while (!halted) @(negedge clk);
    // no more port traffic once halted
    repeat (50) begin
      @(negedge clk);
      assert (halted && !io_req) else begin
        $display("%s: activity or halt loss after the halt word", cur_name);
        err_cnt++;
      end
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d expected outputs never arrived", cur_name, exp_q.size());
      err_cnt++;
    end
    test_cnt++;
    $display("test %s done, %0d errors", cur_name, err_cnt - err_before);
  endtask

  task automatic build_alu();
    stack_cpu_pkg::alu_fn_e fns[10];
    logic [15:0] a;
    logic [15:0] b;
    fns = '{stack_cpu_pkg::alu_pass0, stack_cpu_pkg::alu_pass1, stack_cpu_pkg::alu_add,
            stack_cpu_pkg::alu_sub, stack_cpu_pkg::alu_mul, stack_cpu_pkg::alu_join,
            stack_cpu_pkg::alu_and, stack_cpu_pkg::alu_lt, stack_cpu_pkg::alu_eq,
            stack_cpu_pkg::alu_neq};
    for (int i = 0; i < 10; i++) begin
      take_bits(8, a);
      take_bits(8, b);
      emit(enc(stack_cpu_pkg::op_push, a[7:0]));
      emit(enc(stack_cpu_pkg::op_push, b[7:0]));
      emit(enc(stack_cpu_pkg::op_alu2, fns[i]));
      emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
      expect_out(ref_alu(fns[i], b, a));
    end
    emit(stack_cpu_pkg::insn_halt);
  endtask

  task automatic build_mem();
    logic [15:0] r;
    logic [7:0] ad1;
    logic [7:0] ad2;
    logic [7:0] ad3;
    logic [7:0] v1;
    logic [7:0] v2;
    logic [7:0] v3;
    take_bits(7, r);
    ad1 = 8'h20 + r[7:0];
    take_bits(7, r);
    ad2 = 8'h20 + r[7:0];
    take_bits(7, r);
    ad3 = 8'h20 + r[7:0];
    take_bits(8, r);
    v1 = r[7:0];
    take_bits(8, r);
    v2 = r[7:0];
    take_bits(8, r);
    v3 = r[7:0];
    // st then ld back
    emit(enc(stack_cpu_pkg::op_push, v1));
    emit(enc(stack_cpu_pkg::op_st, ad1));
    emit(enc(stack_cpu_pkg::op_ld, ad1));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out({8'h00, v1});
    // sta leaves the address on top
    emit(enc(stack_cpu_pkg::op_push, v2));
    emit(enc(stack_cpu_pkg::op_push, ad2));
    emit(enc(stack_cpu_pkg::op_sta, 8'h00));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out({8'h00, ad2});
    emit(enc(stack_cpu_pkg::op_ld, ad2));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out({8'h00, v2});
    // std leaves the data on top
    emit(enc(stack_cpu_pkg::op_push, v3));
    emit(enc(stack_cpu_pkg::op_push, ad3));
    emit(enc(stack_cpu_pkg::op_std, 8'h00));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out({8'h00, v3});
    // ldd through a popped address
    emit(enc(stack_cpu_pkg::op_push, ad3));
    emit(enc(stack_cpu_pkg::op_ldd, 8'h00));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out({8'h00, v3});
    emit(stack_cpu_pkg::insn_halt);
  endtask

  task automatic build_flow();
    logic [15:0] r;
    int n;
    take_bits(2, r);
    n = 2 + int'(r[1:0]);
    // countdown body, 7 words, jnz back to its start
    emit(enc(stack_cpu_pkg::op_push, 8'(n)));
    emit(enc(stack_cpu_pkg::op_dup, 8'h00));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    emit(enc(stack_cpu_pkg::op_push, 8'h01));
    emit(enc(stack_cpu_pkg::op_dup, 8'h01));
    emit(enc(stack_cpu_pkg::op_alu2, stack_cpu_pkg::alu_sub));
    emit(enc(stack_cpu_pkg::op_dup, 8'h00));
    emit(enc(stack_cpu_pkg::op_jnz, 8'hfa));
    exec_steps += 7 * (n - 1);
    for (int k = n; k >= 1; k--) begin
      expect_out(16'(k));
    end
    // jz on nonzero falls through
    emit(enc(stack_cpu_pkg::op_push, 8'h05));
    emit(enc(stack_cpu_pkg::op_jz, 8'h02));
    emit(enc(stack_cpu_pkg::op_push, 8'h33));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out(16'h0033);
    // jmp skips one store
    emit(enc(stack_cpu_pkg::op_push, 8'h55));
    emit(enc(stack_cpu_pkg::op_jmp, 8'h02));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out(16'h0055);
    emit(stack_cpu_pkg::insn_halt);
  endtask

  task automatic build_stack();
    logic [15:0] a;
    logic [15:0] b;
    take_bits(8, a);
    take_bits(8, b);
    // dup 0 copies the top
    emit(enc(stack_cpu_pkg::op_push, a[7:0]));
    emit(enc(stack_cpu_pkg::op_push, b[7:0]));
    emit(enc(stack_cpu_pkg::op_dup, 8'h00));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out(b);
    expect_out(b);
    // dup 1 copies the second entry, a stays below
    emit(enc(stack_cpu_pkg::op_push, b[7:0]));
    emit(enc(stack_cpu_pkg::op_dup, 8'h01));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out(a);
    expect_out(b);
    expect_out(a);
    // pop exposes the entry below
    emit(enc(stack_cpu_pkg::op_push, b[7:0]));
    emit(enc(stack_cpu_pkg::op_push, a[7:0]));
    emit(enc(stack_cpu_pkg::op_pop, 8'h00));
    emit(enc(stack_cpu_pkg::op_st, stack_cpu_pkg::io_addr));
    expect_out(b);
    emit(stack_cpu_pkg::insn_halt);
  endtask

  initial begin
    rst = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    run_limit = 1000;
    cur_name = "init";

    start_test("alu");
    build_alu();
    run_program();
    start_test("memory");
    build_mem();
    run_program();
    start_test("control_flow");
    build_flow();
    run_program();
    start_test("stack_ops");
    build_stack();
    run_program();
    // a lone halt word, nothing comes out
    start_test("halt_at_zero");
    emit(stack_cpu_pkg::insn_halt);
    run_program();

    $display("tests %0d, outputs checked %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/stack_cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module stack_cpu_top (
  input  logic clk,
  input  logic rst,
  input  logic prog_we,
  input  logic [stack_cpu_pkg::pc_w-1:0] prog_addr,
  input  logic [stack_cpu_pkg::word_w-1:0] prog_data,
  output logic io_req,
  output logic [stack_cpu_pkg::word_w-1:0] io_data,
  input  logic io_ack,
  output logic halted
);

  // fetch path
  stack_cpu_pkg::insn_t insn;
  logic [stack_cpu_pkg::pc_w-1:0] pc;

  // data path
  stack_cpu_pkg::mem_req_t mem_req;
  logic [stack_cpu_pkg::word_w-1:0] rd_data;
  logic mem_wait;

  program_mem u_prog (
    .clk   (clk),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .pc    (pc),
    .insn  (insn)
  );

  stack_cpu_core u_core (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .rd_data  (rd_data),
    .mem_wait (mem_wait),
    .pc       (pc),
    .mem_req  (mem_req),
    .halted   (halted)
  );

  data_mem u_dmem (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .rd_data  (rd_data),
    .mem_wait (mem_wait),
    .io_req   (io_req),
    .io_data  (io_data),
    .io_ack   (io_ack)
  );

endmodule

`default_nettype wire

// File: source/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem (
  input  logic clk,
  input  logic rst,
  input  stack_cpu_pkg::mem_req_t mem_req,
  output logic [stack_cpu_pkg::word_w-1:0] rd_data,
  output logic mem_wait,
  output logic io_req,
  output logic [stack_cpu_pkg::word_w-1:0] io_data,
  input  logic io_ack
);

  // output port handshake states
  typedef enum logic [1:0] {
    io_idle,
    io_pend,
    io_drop
  } io_state_e;

  io_state_e io_state;
  logic [stack_cpu_pkg::word_w-1:0] ram [224];
  logic is_ram;
  logic io_wr;

  assign is_ram = (mem_req.addr >= stack_cpu_pkg::ram_base);
  assign io_wr = mem_req.wr && (mem_req.addr == stack_cpu_pkg::io_addr);

  // general ram, 20h maps to entry 0
  always_ff @(posedge clk) begin
    if (mem_req.wr && is_ram) begin
      ram[mem_req.addr - stack_cpu_pkg::ram_base] <= mem_req.wr_data;
    end
  end

  // registered read, port and reserved space read zero
  always_ff @(posedge clk) begin
    rd_data <= is_ram ? ram[mem_req.addr - stack_cpu_pkg::ram_base] : '0;
  end

  // port data captured with the write strobe
  always_ff @(posedge clk) begin
    if (io_wr) begin
      io_data <= mem_req.wr_data;
    end
  end

  // four phase req/ack
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      io_state <= io_idle;
    end else begin
      case (io_state)
        io_idle: begin
          if (io_wr) begin
            io_state <= io_pend;
          end
        end
        io_pend: begin
          if (io_ack) begin
            io_state <= io_drop;
          end
        end
        // req is low, waiting for ack to go away
        default: begin
          if (!io_ack) begin
            io_state <= io_idle;
          end
        end
      endcase
    end
  end

  assign io_req = (io_state == io_pend);

  // core holds in update from the strobe until ack falls
  assign mem_wait = io_wr || (io_state == io_pend) || ((io_state == io_drop) && io_ack);

  a_io_data_held: assert property (
    @(posedge clk) disable iff (rst) io_req |=> !io_req || $stable(io_data)
  );

  a_req_after_ack: assert property (
    @(posedge clk) disable iff (rst) $rose(io_req) |-> !io_ack
  );

endmodule

`default_nettype wire

// File: core/stack_cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module stack_cpu_core (
  input  logic clk,
  input  logic rst,
  input  stack_cpu_pkg::insn_t insn,
  input  logic [stack_cpu_pkg::word_w-1:0] rd_data,
  input  logic mem_wait,
  output logic [stack_cpu_pkg::pc_w-1:0] pc,
  output stack_cpu_pkg::mem_req_t mem_req,
  output logic halted
);

  // 0 execute, 1 memory, 2 update
  logic [1:0] phase;
  logic update;
  stack_cpu_pkg::ctrl_t ctrl;
  logic [stack_cpu_pkg::word_w-1:0] alu_out;
  logic [stack_cpu_pkg::word_w-1:0] stack [stack_cpu_pkg::stack_depth];
  logic jump_taken;
  logic is_halt;
  logic [stack_cpu_pkg::pc_w-1:0] pc_offset;
  logic wr_pulse;
  logic [stack_cpu_pkg::word_w-1:0] wr_data_q;

  insn_decoder u_dec (
    .insn (insn),
    .ctrl (ctrl)
  );

  stack_alu u_alu (
    .imm     (ctrl.imm),
    .low     (insn.low),
    .stack0  (stack[0]),
    .stack1  (stack[1]),
    .alu_out (alu_out)
  );

  // update edge, held off while the port write drains
  assign update = (phase == 2'd2) && !mem_wait;
  assign is_halt = (insn == stack_cpu_pkg::insn_halt);

  // sign extended branch offset
  assign pc_offset = {{(stack_cpu_pkg::pc_w - 8){insn.low.imm8[7]}}, insn.low.imm8};

  always_comb begin
    case (ctrl.jmp)
      stack_cpu_pkg::jmp_always: jump_taken = 1'b1;
      stack_cpu_pkg::jmp_zero: jump_taken = (stack[0] == '0);
      stack_cpu_pkg::jmp_nonzero: jump_taken = (stack[0] != '0);
      default: jump_taken = 1'b0;
    endcase
  end

  // phase sequencer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= 2'd0;
    end else if (phase == 2'd2) begin
      if (!mem_wait) begin
        phase <= 2'd0;
      end
    end else begin
      phase <= phase + 2'd1;
    end
  end

  // operand stack
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < stack_cpu_pkg::stack_depth; i++) begin
        stack[i] <= '0;
      end
    end else if (update) begin
      case (ctrl.load)
        stack_cpu_pkg::load_stack1: stack[0] <= stack[1];
        stack_cpu_pkg::load_alu: stack[0] <= alu_out;
        stack_cpu_pkg::load_rd: stack[0] <= rd_data;
        default: stack[0] <= stack[0];
      endcase
      // push shifts down, bottom entry falls off
      if (ctrl.push && !ctrl.pop) begin
        for (int i = 1; i < stack_cpu_pkg::stack_depth; i++) begin
          stack[i] <= stack[i-1];
        end
      end
      // pop shifts up, bottom entry is kept
      if (ctrl.pop && !ctrl.push) begin
        for (int i = 1; i < stack_cpu_pkg::stack_depth - 1; i++) begin
          stack[i] <= stack[i+1];
        end
      end
    end
  end

  // pc, frozen on the halt word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (update && !is_halt) begin
      if (jump_taken) begin
        pc <= pc + pc_offset;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (update && is_halt) begin
      halted <= 1'b1;
    end
  end

  // one cycle write strobe, lands in phase 2
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_pulse <= 1'b0;
    end else begin
      wr_pulse <= (phase == 2'd1) && ctrl.wr;
    end
  end

  // st writes the top, sta/std write the entry below the address
  always_ff @(posedge clk) begin
    if (phase == 2'd1) begin
      wr_data_q <= ctrl.imm ? stack[0] : stack[1];
    end
  end

  // low alu byte is the data address
  assign mem_req.addr = alu_out[stack_cpu_pkg::addr_w-1:0];
  assign mem_req.wr = wr_pulse;
  assign mem_req.wr_data = wr_data_q;

  a_phase_range: assert property (
    @(posedge clk) disable iff (rst) phase != 2'd3
  );

  a_wr_in_update: assert property (
    @(posedge clk) disable iff (rst) mem_req.wr |-> phase == 2'd2
  );

  a_pc_frozen: assert property (
    @(posedge clk) disable iff (rst) halted |=> $stable(pc)
  );

endmodule

`default_nettype wire

// File: core/stack_alu.sv
`timescale 1ns/1ns
`default_nettype none

module stack_alu (
  input  logic imm,
  input  stack_cpu_pkg::insn_low_u low,
  input  logic [stack_cpu_pkg::word_w-1:0] stack0,
  input  logic [stack_cpu_pkg::word_w-1:0] stack1,
  output logic [stack_cpu_pkg::word_w-1:0] alu_out
);

  always_comb begin
    if (imm) begin
      // immediate, also the data address for ld/st
      alu_out = {8'd0, low.imm8};
    end else begin
      case (low.alu_fn)
        stack_cpu_pkg::alu_pass0: alu_out = stack0;
        stack_cpu_pkg::alu_pass1: alu_out = stack1;
        stack_cpu_pkg::alu_add: alu_out = stack0 + stack1;
        stack_cpu_pkg::alu_sub: alu_out = stack0 - stack1;
        // low half of the product only
        stack_cpu_pkg::alu_mul: alu_out = stack0 * stack1;
        // stack1 goes to the high byte
        stack_cpu_pkg::alu_join: alu_out = stack0 | (stack1 << 8);
        stack_cpu_pkg::alu_and: alu_out = stack0 & stack1;
        // compares give 0 or 1, unsigned
        stack_cpu_pkg::alu_lt: begin
          alu_out = {15'd0, stack0 < stack1};
        end
        stack_cpu_pkg::alu_eq: begin
          alu_out = {15'd0, stack0 == stack1};
        end
        stack_cpu_pkg::alu_neq: begin
          alu_out = {15'd0, stack0 != stack1};
        end
        // undefined codes
        default: alu_out = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: core/insn_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module insn_decoder (
  input  stack_cpu_pkg::insn_t insn,
  output stack_cpu_pkg::ctrl_t ctrl
);

  // control words per opcode
  // columns: imm, load(2), rd, wr, pop, push, jmp(2)
  always_comb begin
    case (insn.opcode)
      stack_cpu_pkg::op_push: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b1_10_00_01_00);
      end
      stack_cpu_pkg::op_pop: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b0_01_00_10_00);
      end
      stack_cpu_pkg::op_dup: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b0_00_00_01_00);
        // dup 1 copies the second entry
        if (insn.low.imm8[0]) begin
          ctrl.load = stack_cpu_pkg::load_stack1;
        end
      end
      stack_cpu_pkg::op_ld: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b1_11_10_01_00);
      end
      // address popped, data pushed, so top is replaced
      stack_cpu_pkg::op_ldd: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b0_11_10_11_00);
      end
      stack_cpu_pkg::op_st: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b1_01_01_10_00);
      end
      // sta keeps the address on top
      stack_cpu_pkg::op_sta: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b0_00_01_10_00);
      end
      // std keeps the data on top
      stack_cpu_pkg::op_std: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b0_01_01_10_00);
      end
      stack_cpu_pkg::op_jmp: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b1_00_00_00_01);
      end
      stack_cpu_pkg::op_jz: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b1_01_00_10_10);
      end
      stack_cpu_pkg::op_jnz: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b1_01_00_10_11);
      end
      // result replaces the two operands
      stack_cpu_pkg::op_alu2: begin
        ctrl = stack_cpu_pkg::ctrl_t'(9'b0_10_00_10_00);
      end
      // halt word and unknown opcodes do nothing
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/program_mem.sv
`timescale 1ns/1ns
`default_nettype none

module program_mem (
  input  logic clk,
  input  logic we,
  input  logic [stack_cpu_pkg::pc_w-1:0] waddr,
  input  logic [stack_cpu_pkg::word_w-1:0] wdata,
  input  logic [stack_cpu_pkg::pc_w-1:0] pc,
  output stack_cpu_pkg::insn_t insn
);

  // one word per pc value
  logic [stack_cpu_pkg::word_w-1:0] mem [1 << stack_cpu_pkg::pc_w];

  // load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch is combinational
  assign insn = stack_cpu_pkg::insn_t'(mem[pc]);

endmodule

`default_nettype wire

// File: common/stack_cpu_pkg.sv
`default_nettype none

package stack_cpu_pkg;

  // datapath sizes
  localparam int stack_depth = 8;
  localparam int word_w = 16;
  localparam int pc_w = 10;
  localparam int addr_w = 8;

  // memory map
  // 01h is the output port, 20h and up is RAM
  localparam logic [addr_w-1:0] io_addr = 8'h01;
  localparam logic [addr_w-1:0] ram_base = 8'h20;

  // opcodes, upper byte of the instruction word
  // 00h-07h stack ops
  localparam logic [7:0] op_push = 8'h00;
  localparam logic [7:0] op_pop = 8'h01;
  localparam logic [7:0] op_dup = 8'h02;
  // 08h-0fh memory access
  localparam logic [7:0] op_ld = 8'h08;
  localparam logic [7:0] op_ldd = 8'h09;
  localparam logic [7:0] op_st = 8'h0c;
  localparam logic [7:0] op_sta = 8'h0d;
  localparam logic [7:0] op_std = 8'h0e;
  // 10h-1fh jumps, pc relative
  localparam logic [7:0] op_jmp = 8'h10;
  localparam logic [7:0] op_jz = 8'h11;
  localparam logic [7:0] op_jnz = 8'h12;
  // two operand alu group
  localparam logic [7:0] op_alu2 = 8'h20;
  // whole word, stops the core
  localparam logic [word_w-1:0] insn_halt = 16'hffff;

  // alu function select, low byte of an alu2 instruction
  typedef enum logic [7:0] {
    alu_pass0 = 8'h00,
    alu_pass1 = 8'h01,
    alu_add   = 8'h02,
    alu_sub   = 8'h03,
    alu_mul   = 8'h04,
    alu_join  = 8'h05,
    alu_and   = 8'h06,
    alu_lt    = 8'h08,
    alu_eq    = 8'h09,
    alu_neq   = 8'h0a
  } alu_fn_e;

  // low byte is either an immediate or a function code
  typedef union packed {
    logic [7:0] imm8;
    alu_fn_e alu_fn;
  } insn_low_u;

  typedef struct packed {
    logic [7:0] opcode;
    insn_low_u low;
  } insn_t;

  // new stack top source
  typedef enum logic [1:0] {
    load_keep,
    load_stack1,
    load_alu,
    load_rd
  } load_sel_e;

  // branch condition, tested on stack top
  typedef enum logic [1:0] {
    jmp_none,
    jmp_always,
    jmp_zero,
    jmp_nonzero
  } jmp_cond_e;

  // decoded control word, imm is the msb
  typedef struct packed {
    logic imm;
    load_sel_e load;
    logic rd;
    logic wr;
    logic pop;
    logic push;
    jmp_cond_e jmp;
  } ctrl_t;

  // core to data memory
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic wr;
    logic [word_w-1:0] wr_data;
  } mem_req_t;

endpackage

`default_nettype wire
